// ==== build.f ====
rtl/pipe_pkg.sv
rtl/regfile.sv
rtl/pipe_stage_reg.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/core_top.sv
verification/core_tb.sv

// ==== rtl/core_top.sv ====
`default_nettype none

module core_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pipe_pkg::instr_t   instr,
    input  wire                     in_valid,
    output logic                    in_ready,
    output pipe_pkg::retire_t       retire,
    output logic                    retire_valid
);

    pipe_pkg::id_ex_t  id_out;
    pipe_pkg::id_ex_t  id_q;
    pipe_pkg::ex_mem_t ex_out;
    pipe_pkg::ex_mem_t ex_q;
    pipe_pkg::mem_wb_t mem_out;
    pipe_pkg::mem_wb_t wb_q;
    pipe_pkg::fwd_t    ex_fwd;
    pipe_pkg::fwd_t    mem_fwd;
    logic              id_valid;
    logic              id_q_valid;
    logic              ex_q_valid;
    logic              wb_q_valid;
    logic              ex_nofwd;
    logic              mem_nofwd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    decode_stage decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .in_valid  (in_valid),
        .wb        (wb_q),
        .wb_valid  (wb_q_valid),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .ex_nofwd  (ex_nofwd),
        .mem_nofwd (mem_nofwd),
        .in_ready  (in_ready),
        .id_out    (id_out),
        .id_valid  (id_valid)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (id_valid),
        .in_data   (id_out),
        .bubble    (!id_valid),  // Nothing accepted, empty slot.
        .out_valid (id_q_valid),
        .out_data  (id_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute and memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    exec_stage exec_i (
        .id_in    (id_q),
        .id_valid (id_q_valid),
        .ex_out   (ex_out),
        .ex_fwd   (ex_fwd),
        .ex_nofwd (ex_nofwd)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (id_q_valid),
        .in_data   (ex_out),
        .bubble    (1'b0),
        .out_valid (ex_q_valid),
        .out_data  (ex_q)
    );

    mem_stage mem_i (
        .clk       (clk),
        .ex_in     (ex_q),
        .ex_valid  (ex_q_valid),
        .mem_out   (mem_out),
        .mem_fwd   (mem_fwd),
        .mem_nofwd (mem_nofwd)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ex_q_valid),
        .in_data   (mem_out),
        .bubble    (1'b0),
        .out_valid (wb_q_valid),
        .out_data  (wb_q)
    );

    // Retire in the regfile write cycle.
    assign retire       = wb_q;
    assign retire_valid = wb_q_valid && (|wb_q.wen);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::instr_t    instr,
    input  wire                      in_valid,
    input  wire pipe_pkg::mem_wb_t   wb,
    input  wire                      wb_valid,
    input  wire pipe_pkg::fwd_t      ex_fwd,
    input  wire pipe_pkg::fwd_t      mem_fwd,
    input  wire                      ex_nofwd,
    input  wire                      mem_nofwd,
    output logic                     in_ready,
    output pipe_pkg::id_ex_t         id_out,
    output logic                     id_valid
);

    logic                            use_rs;
    logic                            use_rt;
    logic                            use_imm;
    logic                            writes;
    logic                            ren1;
    logic                            ren2;
    logic [pipe_pkg::reg_addr_w-1:0] raddr2;
    logic [pipe_pkg::xlen-1:0]       rdata1;
    logic [pipe_pkg::xlen-1:0]       rdata2;
    logic [pipe_pkg::xlen-1:0]       imm_ext;
    logic [pipe_pkg::lanes-1:0]      wb_wen;
    logic                            stallreq;

    assign imm_ext = {{(pipe_pkg::xlen-pipe_pkg::imm_w){instr.low.imm16[pipe_pkg::imm_w-1]}},
                      instr.low.imm16};

    always_comb begin
        use_rs          = 1'b1;
        use_rt          = 1'b0;
        use_imm         = 1'b1;
        writes          = 1'b1;
        id_out.is_load  = 1'b0;
        id_out.is_ldb   = 1'b0;
        id_out.is_store = 1'b0;
        case (instr.opcode)
            pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_and,
            pipe_pkg::op_or, pipe_pkg::op_xor: begin
                use_rt  = 1'b1;
                use_imm = 1'b0;
            end
            pipe_pkg::op_addi: begin
                use_imm = 1'b1;
            end
            pipe_pkg::op_lui: begin
                use_rs = 1'b0;
            end
            pipe_pkg::op_lw: begin
                id_out.is_load = 1'b1;
            end
            pipe_pkg::op_ldb: begin
                id_out.is_ldb = 1'b1;  // Lane picked in EX.
            end
            pipe_pkg::op_sw: begin
                use_rt          = 1'b1;
                writes          = 1'b0;
                id_out.is_store = 1'b1;
            end
            default: begin
                use_rs = 1'b0;
                writes = 1'b0;
            end
        endcase

        case (instr.opcode)
            pipe_pkg::op_sub: id_out.alu_op = pipe_pkg::alu_sub;
            pipe_pkg::op_and: id_out.alu_op = pipe_pkg::alu_and;
            pipe_pkg::op_or:  id_out.alu_op = pipe_pkg::alu_or;
            pipe_pkg::op_xor: id_out.alu_op = pipe_pkg::alu_xor;
            pipe_pkg::op_lui: id_out.alu_op = pipe_pkg::alu_lui;
            default:          id_out.alu_op = pipe_pkg::alu_add;
        endcase

        id_out.opa   = rdata1;
        id_out.opb   = use_imm ? imm_ext : rdata2;
        id_out.sdata = rdata2;
        id_out.rd    = instr.rd;
        id_out.wen   = (writes && instr.rd != '0) ? '1 : '0;  // r0 never written.
    end

    assign ren1     = in_valid && use_rs;
    assign ren2     = in_valid && use_rt;
    assign raddr2   = (instr.opcode == pipe_pkg::op_sw) ? instr.rd : instr.low.r.rt;
    assign wb_wen   = wb_valid ? wb.wen : '0;
    assign in_ready = !stallreq;
    assign id_valid = in_valid && in_ready;

    regfile regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ren1      (ren1),
        .ren2      (ren2),
        .raddr1    (instr.rs),
        .raddr2    (raddr2),
        .wb_wen    (wb_wen),
        .wb_waddr  (wb.waddr),
        .wb_wdata  (wb.wdata),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .ex_nofwd  (ex_nofwd),
        .mem_nofwd (mem_nofwd),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .stallreq  (stallreq)
    );

endmodule

`default_nettype wire

// ==== rtl/exec_stage.sv ====
`default_nettype none

module exec_stage (
    input  wire pipe_pkg::id_ex_t  id_in,
    input  wire                    id_valid,
    output pipe_pkg::ex_mem_t      ex_out,
    output pipe_pkg::fwd_t         ex_fwd,
    output logic                   ex_nofwd
);

    localparam int iw = pipe_pkg::imm_w;

    logic [pipe_pkg::xlen-1:0]  result;
    logic [pipe_pkg::lanes-1:0] lane_oh;

    always_comb begin
        case (id_in.alu_op)
            pipe_pkg::alu_sub: result = id_in.opa - id_in.opb;
            pipe_pkg::alu_and: result = id_in.opa & id_in.opb;
            pipe_pkg::alu_or:  result = id_in.opa | id_in.opb;
            pipe_pkg::alu_xor: result = id_in.opa ^ id_in.opb;
            pipe_pkg::alu_lui: result = {id_in.opb[iw-1:0], {(pipe_pkg::xlen-iw){1'b0}}};
            default:           result = id_in.opa + id_in.opb;
        endcase
    end

    // Low address bits select the LDB lane.
    assign lane_oh = {{(pipe_pkg::lanes-1){1'b0}}, 1'b1} << result[pipe_pkg::lane_aw-1:0];

    always_comb begin
        ex_out.result   = result;
        ex_out.sdata    = id_in.sdata;
        ex_out.rd       = id_in.rd;
        ex_out.wen      = id_in.is_ldb ? (lane_oh & id_in.wen) : id_in.wen;
        ex_out.is_load  = id_in.is_load;
        ex_out.is_ldb   = id_in.is_ldb;
        ex_out.is_store = id_in.is_store;
    end

    always_comb begin
        ex_fwd.wen   = id_valid ? ex_out.wen : '0;
        ex_fwd.waddr = id_in.rd;
        ex_fwd.wdata = result;
    end

    assign ex_nofwd = id_valid && (id_in.is_load || id_in.is_ldb);  // Data not read yet.

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  wire                     clk,
    input  wire pipe_pkg::ex_mem_t  ex_in,
    input  wire                     ex_valid,
    output pipe_pkg::mem_wb_t       mem_out,
    output pipe_pkg::fwd_t          mem_fwd,
    output logic                    mem_nofwd
);

    localparam int lw = pipe_pkg::lane_w;
    localparam int aw = pipe_pkg::lane_aw;

    logic [pipe_pkg::xlen-1:0]    dmem [pipe_pkg::dmem_words];
    logic [pipe_pkg::dmem_aw-1:0] idx;
    logic [pipe_pkg::xlen-1:0]    word;
    logic [pipe_pkg::xlen-1:0]    byte_word;

    assign idx  = ex_in.result[pipe_pkg::dmem_aw+aw-1:aw];  // Word index.
    assign word = dmem[idx];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_in.is_store) begin
            dmem[idx] <= ex_in.sdata;
        end
    end

    // Byte stays in its own lane, the rest read as zero.
    for (genvar l = 0; l < pipe_pkg::lanes; l++) begin : g_lane
        assign byte_word[l*lw +: lw] = ex_in.wen[l] ? word[l*lw +: lw] : '0;
    end

    always_comb begin
        mem_out.waddr = ex_in.rd;
        mem_out.wen   = ex_in.wen;
        if (ex_in.is_load) begin
            mem_out.wdata = word;
        end else if (ex_in.is_ldb) begin
            mem_out.wdata = byte_word;
        end else begin
            mem_out.wdata = ex_in.result;
        end
    end

    always_comb begin
        mem_fwd.wen   = ex_valid ? ex_in.wen : '0;
        mem_fwd.waddr = ex_in.rd;
        mem_fwd.wdata = mem_out.wdata;
    end

    assign mem_nofwd = ex_valid && ex_in.is_ldb;  // Partial word, merged at WB.

    ldb_one_lane: assert property (@(posedge clk)
        ex_valid && ex_in.is_ldb && ex_in.rd != '0 |-> $onehot(ex_in.wen));

endmodule

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;
    localparam int dmem_words = 64;
    localparam int dmem_aw    = $clog2(dmem_words);
    localparam int lanes      = 4;
    localparam int lane_w     = xlen / lanes;  // Bits per byte lane.
    localparam int lane_aw    = $clog2(lanes); // Byte offset bits of an address.
    localparam int imm_w      = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        op_nop  = 6'd0,
        op_add  = 6'd1,
        op_sub  = 6'd2,
        op_and  = 6'd3,
        op_or   = 6'd4,
        op_xor  = 6'd5,
        op_addi = 6'd6,
        op_lui  = 6'd7,
        op_sw   = 6'd8,  // Stores the register named in rd.
        op_lw   = 6'd9,
        op_ldb  = 6'd10
    } opcode_e;

    // Register form of the low half, rt on top.
    typedef struct packed {
        logic [reg_addr_w-1:0]       rt;
        logic [imm_w-reg_addr_w-1:0] pad;
    } rt_field_t;

    typedef union packed {
        logic [imm_w-1:0] imm16;
        rt_field_t        r;
    } low_field_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        low_field_t            low;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_lui
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        alu_op_e               alu_op;
        logic [xlen-1:0]       opa;
        logic [xlen-1:0]       opb;
        logic [xlen-1:0]       sdata;
        logic [reg_addr_w-1:0] rd;
        logic [lanes-1:0]      wen;
        logic                  is_load;
        logic                  is_ldb;
        logic                  is_store;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       result;  // Also the memory address.
        logic [xlen-1:0]       sdata;
        logic [reg_addr_w-1:0] rd;
        logic [lanes-1:0]      wen;
        logic                  is_load;
        logic                  is_ldb;
        logic                  is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] waddr;
        logic [lanes-1:0]      wen;
        logic [xlen-1:0]       wdata;
    } mem_wb_t;

    typedef struct packed {
        logic [lanes-1:0]      wen;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } fwd_t;

    typedef mem_wb_t retire_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_stage_reg.sv ====
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           in_valid,
    input  wire payload_t in_data,
    input  wire           bubble,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && !bubble;  // Bubble loads an empty slot.
        end
    end

    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    valid_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !out_valid);

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`default_nettype none

module regfile (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              ren1,
    input  wire                              ren2,
    input  wire [pipe_pkg::reg_addr_w-1:0]   raddr1,
    input  wire [pipe_pkg::reg_addr_w-1:0]   raddr2,
    input  wire [pipe_pkg::lanes-1:0]        wb_wen,
    input  wire [pipe_pkg::reg_addr_w-1:0]   wb_waddr,
    input  wire [pipe_pkg::xlen-1:0]         wb_wdata,
    input  wire pipe_pkg::fwd_t              ex_fwd,
    input  wire pipe_pkg::fwd_t              mem_fwd,
    input  wire                              ex_nofwd,
    input  wire                              mem_nofwd,
    output logic [pipe_pkg::xlen-1:0]        rdata1,
    output logic [pipe_pkg::xlen-1:0]        rdata2,
    output logic                             stallreq
);

    localparam int lw = pipe_pkg::lane_w;

    logic [pipe_pkg::xlen-1:0]       gpr   [pipe_pkg::nregs];
    logic                            ren   [2];
    logic [pipe_pkg::reg_addr_w-1:0] raddr [2];
    logic [pipe_pkg::xlen-1:0]       rdata [2];
    logic [1:0]                      stall_p;

    assign ren[0]   = ren1;
    assign ren[1]   = ren2;
    assign raddr[0] = raddr1;
    assign raddr[1] = raddr2;
    assign rdata1   = rdata[0];
    assign rdata2   = rdata[1];
    assign stallreq = |stall_p;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port, one enable per byte lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < pipe_pkg::nregs; r++) begin
                gpr[r] <= '0;
            end
        end else begin
            for (int l = 0; l < pipe_pkg::lanes; l++) begin
                if (wb_wen[l]) begin
                    gpr[wb_waddr][l*lw +: lw] <= wb_wdata[l*lw +: lw];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports with bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar p = 0; p < 2; p++) begin : g_port
        logic                      ex_hit;
        logic                      mem_hit;
        logic                      rvalid;
        logic [pipe_pkg::xlen-1:0] merged;

        // Any lane counts, an LDB in flight writes a single one.
        assign ex_hit  = (raddr[p] == ex_fwd.waddr) && (|ex_fwd.wen);
        assign mem_hit = (raddr[p] == mem_fwd.waddr) && (|mem_fwd.wen);
        assign rvalid  = ren[p] && (raddr[p] != '0);

        for (genvar l = 0; l < pipe_pkg::lanes; l++) begin : g_lane
            assign merged[l*lw +: lw] = (raddr[p] == wb_waddr && wb_wen[l]) ?
                                        wb_wdata[l*lw +: lw] :
                                        gpr[raddr[p]][l*lw +: lw];
        end

        assign rdata[p] = (raddr[p] == '0) ? '0            :
                          ex_hit           ? ex_fwd.wdata  :
                          mem_hit          ? mem_fwd.wdata :
                          merged;

        // Producer hit that cannot hand its value over yet.
        assign stall_p[p] = rvalid && ((ex_hit && ex_nofwd) || (mem_hit && mem_nofwd));
    end

    stall_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        !(ren1 || ren2) |-> !stallreq);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_tb -f build.f -o core_tb || exit 1
out=$(./obj_dir/core_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== verification/core_tb.sv ====
`default_nettype none

module core_tb;

    localparam int n_directed = 23;
    localparam int n_fill     = 3 * pipe_pkg::dmem_words;
    localparam int n_random   = 300;
    localparam int timeout_cy = 40 * (n_directed + n_fill + n_random) + 100;
    localparam int load_stall = 1;  // Load sits in EX one cycle, then MEM forwards.
    localparam int ldb_stall  = 2;  // EX cycle plus the cycle in MEM.

    logic              clk;
    logic              rst_n;
    pipe_pkg::instr_t  instr;
    logic              in_valid;
    logic              in_ready;
    pipe_pkg::retire_t retire;
    logic              retire_valid;

    logic [pipe_pkg::xlen-1:0] model_regs [pipe_pkg::nregs];
    logic [pipe_pkg::xlen-1:0] model_mem  [pipe_pkg::dmem_words];
    pipe_pkg::retire_t         exp_q [$];
    integer                    seed;
    int                        stalls;

    core_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, want));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic pipe_pkg::retire_t exec_model(input pipe_pkg::instr_t ins);
        pipe_pkg::retire_t         res;
        logic [pipe_pkg::xlen-1:0] a;
        logic [pipe_pkg::xlen-1:0] b;
        logic [pipe_pkg::xlen-1:0] imm;
        logic [pipe_pkg::xlen-1:0] addr;
        logic [pipe_pkg::xlen-1:0] word;
        a         = model_regs[ins.rs];
        b         = model_regs[ins.low.r.rt];
        imm       = {{16{ins.low.imm16[15]}}, ins.low.imm16};
        addr      = a + imm;
        word      = model_mem[addr[7:2]];  // Word index.
        res.waddr = ins.rd;
        res.wen   = 4'hf;
        res.wdata = '0;
        case (ins.opcode)
            pipe_pkg::op_add:  res.wdata = a + b;
            pipe_pkg::op_sub:  res.wdata = a - b;
            pipe_pkg::op_and:  res.wdata = a & b;
            pipe_pkg::op_or:   res.wdata = a | b;
            pipe_pkg::op_xor:  res.wdata = a ^ b;
            pipe_pkg::op_addi: res.wdata = a + imm;
            pipe_pkg::op_lui:  res.wdata = {ins.low.imm16, 16'h0000};
            pipe_pkg::op_lw:   res.wdata = word;
            pipe_pkg::op_ldb: begin
                res.wen   = 4'b0001 << addr[1:0];
                res.wdata = word & (32'h0000_00ff << {addr[1:0], 3'b000});
            end
            pipe_pkg::op_sw: begin
                model_mem[addr[7:2]] = model_regs[ins.rd];
                res.wen              = '0;
            end
            default: res.wen = '0;
        endcase
        if (ins.rd == '0) begin
            res.wen = '0;
        end
        for (int l = 0; l < 4; l++) begin
            if (res.wen[l]) begin
                model_regs[ins.rd][l*8 +: 8] = res.wdata[l*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic pipe_pkg::instr_t rr_instr(input pipe_pkg::opcode_e op,
                                                  input logic [4:0] rd,
                                                  input logic [4:0] rs,
                                                  input logic [4:0] rt);
        pipe_pkg::instr_t ins;
        ins.opcode    = op;
        ins.rd        = rd;
        ins.rs        = rs;
        ins.low.imm16 = {rt, 11'd0};
        return ins;
    endfunction

    function automatic pipe_pkg::instr_t imm_instr(input pipe_pkg::opcode_e op,
                                                   input logic [4:0] rd,
                                                   input logic [4:0] rs,
                                                   input logic [15:0] imm);
        pipe_pkg::instr_t ins;
        ins.opcode    = op;
        ins.rd        = rd;
        ins.rs        = rs;
        ins.low.imm16 = imm;
        return ins;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_instr(input pipe_pkg::instr_t ins);
        pipe_pkg::retire_t want;
        logic              taken;
        instr    <= ins;
        in_valid <= 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;  // Stable until the next edge.
            if (!in_ready) begin
                stalls++;
            end
            @(posedge clk);
        end
        want = exec_model(ins);
        if (want.wen != '0) begin
            exp_q.push_back(want);
        end
    endtask

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic alu_forward_chain();
        stalls = 0;
        send_instr(imm_instr(pipe_pkg::op_lui, 5'd1, 5'd0, 16'h1234));
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd1, 5'd1, 16'h5678));
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd2, 5'd1, 16'hffff));
        send_instr(rr_instr(pipe_pkg::op_add, 5'd3, 5'd1, 5'd2));
        send_instr(rr_instr(pipe_pkg::op_sub, 5'd4, 5'd3, 5'd1));
        send_instr(rr_instr(pipe_pkg::op_xor, 5'd5, 5'd4, 5'd3));
        send_instr(rr_instr(pipe_pkg::op_and, 5'd6, 5'd5, 5'd1));
        send_instr(rr_instr(pipe_pkg::op_or, 5'd7, 5'd6, 5'd2));
        compare("in_ready low cycles in ALU chain", stalls, 0);
    endtask

    task automatic r0_writes();
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd0, 5'd1, 16'h0005));
        send_instr(imm_instr(pipe_pkg::op_lui, 5'd0, 5'd0, 16'hffff));
        send_instr(rr_instr(pipe_pkg::op_add, 5'd2, 5'd0, 5'd0));
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd3, 5'd0, 16'h0007));
        send_instr(rr_instr(pipe_pkg::op_or, 5'd4, 5'd0, 5'd1));
    endtask

    task automatic memory_fill();
        logic [15:0] idx;
        for (int i = 0; i < pipe_pkg::dmem_words; i++) begin
            idx = 16'(i);
            send_instr(imm_instr(pipe_pkg::op_lui, 5'd1, 5'd0, 16'ha500 + idx * 16'h0103));
            send_instr(imm_instr(pipe_pkg::op_addi, 5'd1, 5'd1,
                                 (idx * 16'h0221) ^ 16'h01c3));
            send_instr(imm_instr(pipe_pkg::op_sw, 5'd1, 5'd0, {idx[13:0], 2'b00}));
        end
    endtask

    task automatic load_use_stall();
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd1, 5'd0, 16'h0bad));
        send_instr(imm_instr(pipe_pkg::op_sw, 5'd1, 5'd0, 16'h0008));
        send_instr(imm_instr(pipe_pkg::op_lw, 5'd2, 5'd0, 16'h0008));
        stalls = 0;
        send_instr(rr_instr(pipe_pkg::op_add, 5'd3, 5'd2, 5'd1));
        compare("in_ready low cycles after LW", stalls, load_stall);
    endtask

    // One byte from each of words 4 to 7, each into its own lane of r4.
    task automatic byte_merge();
        send_instr(imm_instr(pipe_pkg::op_addi, 5'd4, 5'd0, 16'hffff));
        send_instr(imm_instr(pipe_pkg::op_ldb, 5'd4, 5'd0, 16'h0010));
        send_instr(imm_instr(pipe_pkg::op_ldb, 5'd4, 5'd0, 16'h0015));
        send_instr(imm_instr(pipe_pkg::op_ldb, 5'd4, 5'd0, 16'h001a));
        send_instr(imm_instr(pipe_pkg::op_ldb, 5'd4, 5'd0, 16'h001f));
        stalls = 0;
        send_instr(rr_instr(pipe_pkg::op_add, 5'd6, 5'd4, 5'd0));
        compare("in_ready low cycles after LDB", stalls, ldb_stall);
    endtask

    task automatic random_stream();
        logic [31:0]       r;
        logic [15:0]       imm;
        logic [4:0]        rd;
        logic [4:0]        rs;
        logic [4:0]        rt;
        pipe_pkg::opcode_e op;
        pipe_pkg::instr_t  ins;
        for (int n = 0; n < n_random; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                idle_cycle();
            end
            op  = pipe_pkg::opcode_e'(6'(r[31:8] % 24'd11));
            rd  = {2'b00, r[4:2]};
            rs  = {2'b00, r[7:5]};
            r   = $random(seed);
            rt  = {2'b00, r[18:16]};
            imm = r[15:0];
            case (op)
                pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_and,
                pipe_pkg::op_or, pipe_pkg::op_xor: ins = rr_instr(op, rd, rs, rt);
                pipe_pkg::op_sw, pipe_pkg::op_lw,
                pipe_pkg::op_ldb: ins = imm_instr(op, rd, 5'd0, {8'h00, imm[7:0]});
                default:          ins = imm_instr(op, rd, rs, imm);
            endcase
            send_instr(ins);
        end
    endtask

    initial begin : stimulus
        seed     = 1;
        stalls   = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        for (int r = 0; r < pipe_pkg::nregs; r++) begin
            model_regs[r] = '0;
        end
        for (int w = 0; w < pipe_pkg::dmem_words; w++) begin
            model_mem[w] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        alu_forward_chain();
        r0_writes();
        memory_fill();
        load_use_stall();
        byte_merge();
        random_stream();
        in_valid <= 1'b0;
        for (int k = 0; k < 12 && exp_q.size() != 0; k++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // Room for stray retires.
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected retires never left the pipeline",
                                     exp_q.size()));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        pipe_pkg::retire_t want;
        if (rst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("A register write retired while none was expected");
            end else begin
                want = exp_q.pop_front();
                compare("retire.waddr", 32'(retire.waddr), 32'(want.waddr));
                compare("retire.wen", 32'(retire.wen), 32'(want.wen));
                compare("retire.wdata", retire.wdata, want.wdata);
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cy) @(posedge clk);
        report_failure($sformatf("Timeout after %0d cycles, %0d retires still expected",
                                 timeout_cy, exp_q.size()));
    end

endmodule

`default_nettype wire
